//--- commitCore_tests.txt
# D count then per slot: valid pc dstWe logical phys stale kind predTaken predTarget bim
# C idx slot taken target; R pc; F phys; B pc target taken bim; M addr data; L full; E; Q
D 1 1 100 1 01 14 01 0 0 000 0 0 000 0 00 00 00 0 0 000 0
D 1 1 108 1 03 16 03 0 0 000 0 1 10c 1 03 17 16 0 0 000 0
C 1 1 0 000
C 1 0 0 000
C 0 0 0 000
F 01
F 03
F 16
M 01 14
M 03 17
D 1 1 200 0 00 00 00 1 1 300 2 1 204 1 04 18 04 0 0 000 0
D 1 1 208 1 05 19 05 0 0 000 0 1 20c 1 06 1a 06 0 0 000 0
C 2 1 0 000
C 2 0 0 000
R 208
F 04
B 200 000 0 2
E
D 1 1 280 0 00 00 00 3 1 500 3 1 284 0 00 00 00 0 0 000 0
C 0 1 0 000
C 0 0 1 520
R 520
B 280 520 1 3
E
D 1 1 2c0 0 00 00 00 2 1 600 0 1 2c4 1 08 1c 08 0 0 000 0
C 0 0 1 600
C 0 1 0 000
F 08
B 2c0 600 1 0
Q
D 1 1 300 0 00 00 00 1 0 000 1 0 000 0 00 00 00 0 0 000 0
D 1 1 304 1 09 1d 09 0 0 000 0 0 000 0 00 00 00 0 0 000 0
C 1 0 1 700
B 300 700 1 1
Q
C 2 0 0 000
R 700
F 09
E
D 4 1 400 1 0b 1f 0b 0 0 000 0 0 000 0 00 00 00 0 0 000 0
L 1
D 1 1 404 1 0c 20 0c 0 0 000 0 0 000 0 00 00 00 0 0 000 0
L 1
C 0 0 0 000
C 1 0 0 000
C 2 0 0 000
C 3 0 0 000
F 0b
F 0b
F 0b
F 0b
E

//--- vlog.f
commitPkg.sv
robQueue.sv
commitStage.sv
archRenameTable.sv
commitCore.sv
commitCore_props.sv
commitCore_tb.sv

//--- Bender.yml
package:
  name: commit_core

sources:
  - commitPkg.sv
  - robQueue.sv
  - commitStage.sv
  - archRenameTable.sv
  - commitCore.sv
  - target: test
    files:
      - commitCore_props.sv
      - commitCore_tb.sv

//--- commitCore_tb.sv
`timescale 1ns/1ps

module commitCore_tb import commitPkg::*; ();

    localparam int robDepth  = 4;
    localparam int idxWidth  = $clog2(robDepth);
    localparam int waitLimit = 200;   // Cycles per wait

    logic                    clk;
    logic                    rst;
    logic                    dispatchValid;
    uopEntry                 dispatchUop0;
    uopEntry                 dispatchUop1;
    logic                    robFull;
    logic                    robEmpty;
    logic                    completeValid;
    logic [idxWidth-1:0]     completeIndex;
    logic                    completeSlot;
    logic                    completeTaken;
    logic [pcWidth-1:0]      completeTarget;
    logic                    redirect;
    logic [pcWidth-1:0]      redirectPc;
    logic                    flushReq;
    logic                    bpUpdateValid;
    logic [pcWidth-1:0]      bpUpdatePc;
    logic [pcWidth-1:0]      bpUpdateTarget;
    logic                    bpUpdateTaken;
    logic [1:0]              bpUpdateBim;
    logic                    freeValid0;
    logic                    freeValid1;
    logic [physRegWidth-1:0] freePhys0;
    logic [physRegWidth-1:0] freePhys1;
    logic [archRegWidth-1:0] archMapAddr;
    logic [physRegWidth-1:0] archMapData;

    // Records seen on the DUT outputs, consumed in order by expectations
    logic [pcWidth+1:0]      redirectQ [$];   // Redirect, flush and target
    logic [66:0]             bpQ [$];
    logic [physRegWidth-1:0] freeQ [$];

    int  fd;
    int  seed;
    int  gap;
    int  valueErrors;
    int  otherErrors;
    byte op;

    commitCore #(.robDepth(robDepth)) dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(negedge clk) begin
        if (!rst) begin
            if (redirect || flushReq) begin
                redirectQ.push_back({redirect, flushReq, redirectPc});
            end
            if (bpUpdateValid) begin
                bpQ.push_back({bpUpdatePc, bpUpdateTarget, bpUpdateTaken, bpUpdateBim});
            end
            if (freeValid0) freeQ.push_back(freePhys0);   // Slot 0 first
            if (freeValid1) freeQ.push_back(freePhys1);
        end
    end

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
            valueErrors++;
        end
    endtask

    function automatic int pendingCount(input byte which);
        case (which)
            "R":     return redirectQ.size();
            "B":     return bpQ.size();
            default: return freeQ.size();
        endcase
    endfunction

    task automatic awaitRecord(input byte which, output bit ok);
        int n;
        n = 0;
        while (pendingCount(which) == 0 && n < waitLimit) begin
            @(negedge clk);
            n++;
        end
        ok = pendingCount(which) != 0;
        if (!ok) begin
            $display("Timed out waiting for the DUT to produce a %c record", which);
            otherErrors++;
        end
    endtask

    task automatic readSlot(output uopEntry u);
        logic [31:0] f [10];
        int          cnt;
        cnt = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h",
                      f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9]);
        if (cnt != 10) begin
            $display("Dispatch record in the test file is incomplete");
            otherErrors++;
        end
        u            = '0;
        u.valid      = f[0][0];
        u.pc         = f[1];
        u.dstWe      = f[2][0];
        u.dstLogical = f[3][archRegWidth-1:0];
        u.dstPhys    = f[4][physRegWidth-1:0];
        u.dstStale   = f[5][physRegWidth-1:0];
        u.kind       = branchKind'(f[6][1:0]);
        u.predTaken  = f[7][0];
        u.predTarget = f[8];
        u.bimState   = f[9][1:0];
    endtask

    task automatic runRecord(input byte kindSel);
        logic [31:0]        f [4];
        logic [66:0]        bp;
        logic [pcWidth+1:0] rd;
        uopEntry            u0;
        uopEntry            u1;
        int                 n;
        int                 cnt;
        bit                 ok;
        string              line;
        case (kindSel)
            "#": cnt = $fgets(line, fd);
            "D": begin
                cnt = $fscanf(fd, "%d", n);
                readSlot(u0);
                readSlot(u1);
                repeat (n) begin
                    @(posedge clk);
                    dispatchValid <= 1'b1;
                    dispatchUop0  <= u0;
                    dispatchUop1  <= u1;
                    @(posedge clk);
                    dispatchValid <= 1'b0;
                end
            end
            "C": begin
                cnt = $fscanf(fd, "%h %h %h %h", f[0], f[1], f[2], f[3]);
                @(posedge clk);
                completeValid  <= 1'b1;
                completeIndex  <= f[0][idxWidth-1:0];
                completeSlot   <= f[1][0];
                completeTaken  <= f[2][0];
                completeTarget <= f[3];
                @(posedge clk);
                completeValid  <= 1'b0;
            end
            "R": begin
                cnt = $fscanf(fd, "%h", f[0]);
                awaitRecord("R", ok);
                if (ok) begin
                    rd = redirectQ.pop_front();
                    checkValue("redirect", rd[pcWidth+1], 1);
                    checkValue("flushReq", rd[pcWidth], 1);
                    checkValue("redirectPc", rd[pcWidth-1:0], f[0]);
                end
            end
            "F": begin
                cnt = $fscanf(fd, "%h", f[0]);
                awaitRecord("F", ok);
                if (ok) checkValue("freePhys", freeQ.pop_front(), f[0]);
            end
            "B": begin
                cnt = $fscanf(fd, "%h %h %h %h", f[0], f[1], f[2], f[3]);
                awaitRecord("B", ok);
                if (ok) begin
                    bp = bpQ.pop_front();
                    checkValue("bpUpdatePc", bp[66:35], f[0]);
                    checkValue("bpUpdateTarget", bp[34:3], f[1]);
                    checkValue("bpUpdateTaken", bp[2], f[2]);
                    checkValue("bpUpdateBim", bp[1:0], f[3]);
                end
            end
            "M": begin
                cnt = $fscanf(fd, "%h %h", f[0], f[1]);
                @(posedge clk);
                archMapAddr <= f[0][archRegWidth-1:0];
                @(negedge clk);
                checkValue("archMapData", archMapData, f[1]);
            end
            "L": begin
                cnt = $fscanf(fd, "%h", f[0]);
                @(negedge clk);
                checkValue("robFull", robFull, f[0]);
            end
            "E": begin
                n = 0;
                while (!robEmpty && n < waitLimit) begin
                    @(negedge clk);
                    n++;
                end
                if (!robEmpty) begin
                    $display("Timed out waiting for the reorder buffer to empty");
                    otherErrors++;
                end
            end
            "Q": begin
                if (redirectQ.size() != 0) begin
                    $display("Redirect or flush raised without a retired misprediction");
                    otherErrors++;
                end
            end
            default: begin
                $display("Unknown record type %c in the test file", kindSel);
                otherErrors++;
            end
        endcase
    endtask

    initial begin
        rst            = 1'b1;
        dispatchValid  = 1'b0;
        dispatchUop0   = '0;
        dispatchUop1   = '0;
        completeValid  = 1'b0;
        completeIndex  = '0;
        completeSlot   = 1'b0;
        completeTaken  = 1'b0;
        completeTarget = '0;
        archMapAddr    = '0;
        seed           = 84878;
        valueErrors    = 0;
        otherErrors    = 0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        fd = $fopen("commitCore_tests.txt", "r");
        if (fd == 0) begin
            $display("Cannot open commitCore_tests.txt");
            otherErrors++;
        end else begin
            while ($fscanf(fd, " %c", op) == 1) begin
                runRecord(op);
                gap = $unsigned($random(seed)) % 4;   // Idle cycles between records
                repeat (gap) @(posedge clk);
            end
            $fclose(fd);
        end

        repeat (10) @(posedge clk);
        if (redirectQ.size() != 0 || bpQ.size() != 0 || freeQ.size() != 0) begin
            $display("Unexpected DUT records left: %0d redirect, %0d predictor, %0d free",
                     redirectQ.size(), bpQ.size(), freeQ.size());
            otherErrors++;
        end
        otherErrors += dut0.props0.failCount;
        $display("Errors: %0d value mismatches, %0d other failures", valueErrors, otherErrors);
        if (valueErrors == 0 && otherErrors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- commitCore_props.sv
`timescale 1ns/1ps

module commitCoreProps (
    input logic clk,
    input logic rst,
    input logic redirect,
    input logic flushReq,
    input logic robEmpty,
    input logic headValid
);

    int failCount = 0;   // Read by the testbench at the end of the run

    // Redirect is a one-cycle pulse
    redirectPulse: assert property (@(posedge clk) disable iff (rst) redirect |=> !redirect)
        else begin
            $error("redirect stayed high for more than one cycle");
            failCount++;
        end

    flushEmpties: assert property (@(posedge clk) disable iff (rst) flushReq |=> robEmpty)
        else begin
            $error("robEmpty did not follow flushReq");
            failCount++;
        end

    noHeadWhenEmpty: assert property (@(posedge clk) disable iff (rst) !(headValid && robEmpty))
        else begin
            $error("headValid high while the buffer is empty");
            failCount++;
        end

endmodule

bind commitCore commitCoreProps props0 (
    .clk      (clk),
    .rst      (rst),
    .redirect (redirect),
    .flushReq (flushReq),
    .robEmpty (robEmpty),
    .headValid(headValid)
);

//--- commitCore.sv
`timescale 1ns/1ps

module commitCore import commitPkg::*; #(
    parameter int  robDepth = 8,
    localparam int idxWidth = $clog2(robDepth)
) (
    input  logic                    clk,
    input  logic                    rst,

    input  logic                    dispatchValid,
    input  uopEntry                 dispatchUop0,
    input  uopEntry                 dispatchUop1,
    output logic                    robFull,
    output logic                    robEmpty,

    input  logic                    completeValid,
    input  logic [idxWidth-1:0]     completeIndex,
    input  logic                    completeSlot,
    input  logic                    completeTaken,
    input  logic [pcWidth-1:0]      completeTarget,

    output logic                    redirect,
    output logic [pcWidth-1:0]      redirectPc,
    output logic                    flushReq,

    output logic                    bpUpdateValid,
    output logic [pcWidth-1:0]      bpUpdatePc,
    output logic [pcWidth-1:0]      bpUpdateTarget,
    output logic                    bpUpdateTaken,
    output logic [1:0]              bpUpdateBim,

    output logic                    freeValid0,
    output logic                    freeValid1,
    output logic [physRegWidth-1:0] freePhys0,
    output logic [physRegWidth-1:0] freePhys1,

    input  logic [archRegWidth-1:0] archMapAddr,
    output logic [physRegWidth-1:0] archMapData
);

    logic                    headValid;
    logic                    headRetire;
    uopEntry                 headUop0;
    uopEntry                 headUop1;
    logic                    retireValid0;
    logic                    retireValid1;
    logic [archRegWidth-1:0] retireLogical0;
    logic [archRegWidth-1:0] retireLogical1;
    logic [physRegWidth-1:0] retirePhys0;
    logic [physRegWidth-1:0] retirePhys1;
    logic [physRegWidth-1:0] retireStale0;
    logic [physRegWidth-1:0] retireStale1;

    robQueue #(
        .robDepth(robDepth)
    ) rob0 (
        .clk           (clk),
        .rst           (rst),
        .dispatchValid (dispatchValid),
        .dispatchUop0  (dispatchUop0),
        .dispatchUop1  (dispatchUop1),
        .completeValid (completeValid),
        .completeIndex (completeIndex),
        .completeSlot  (completeSlot),
        .completeTaken (completeTaken),
        .completeTarget(completeTarget),
        .headRetire    (headRetire),
        .flush         (flushReq),       // Flush comes back from commit
        .headValid     (headValid),
        .headUop0      (headUop0),
        .headUop1      (headUop1),
        .robFull       (robFull),
        .robEmpty      (robEmpty)
    );

    commitStage commit0 (
        .clk           (clk),
        .rst           (rst),
        .headValid     (headValid),
        .headUop0      (headUop0),
        .headUop1      (headUop1),
        .headRetire    (headRetire),
        .retireValid0  (retireValid0),
        .retireValid1  (retireValid1),
        .retireLogical0(retireLogical0),
        .retireLogical1(retireLogical1),
        .retirePhys0   (retirePhys0),
        .retirePhys1   (retirePhys1),
        .retireStale0  (retireStale0),
        .retireStale1  (retireStale1),
        .redirect      (redirect),
        .redirectPc    (redirectPc),
        .flushReq      (flushReq),
        .bpUpdateValid (bpUpdateValid),
        .bpUpdatePc    (bpUpdatePc),
        .bpUpdateTarget(bpUpdateTarget),
        .bpUpdateTaken (bpUpdateTaken),
        .bpUpdateBim   (bpUpdateBim)
    );

    archRenameTable rename0 (
        .clk           (clk),
        .rst           (rst),
        .retireValid0  (retireValid0),
        .retireValid1  (retireValid1),
        .retireLogical0(retireLogical0),
        .retireLogical1(retireLogical1),
        .retirePhys0   (retirePhys0),
        .retirePhys1   (retirePhys1),
        .retireStale0  (retireStale0),
        .retireStale1  (retireStale1),
        .freeValid0    (freeValid0),
        .freeValid1    (freeValid1),
        .freePhys0     (freePhys0),
        .freePhys1     (freePhys1),
        .archMapAddr   (archMapAddr),
        .archMapData   (archMapData)
    );

endmodule

//--- archRenameTable.sv
`timescale 1ns/1ps

module archRenameTable import commitPkg::*; (
    input  logic                    clk,
    input  logic                    rst,

    input  logic                    retireValid0,
    input  logic                    retireValid1,
    input  logic [archRegWidth-1:0] retireLogical0,
    input  logic [archRegWidth-1:0] retireLogical1,
    input  logic [physRegWidth-1:0] retirePhys0,
    input  logic [physRegWidth-1:0] retirePhys1,
    input  logic [physRegWidth-1:0] retireStale0,
    input  logic [physRegWidth-1:0] retireStale1,

    output logic                    freeValid0,
    output logic                    freeValid1,
    output logic [physRegWidth-1:0] freePhys0,
    output logic [physRegWidth-1:0] freePhys1,

    input  logic [archRegWidth-1:0] archMapAddr,
    output logic [physRegWidth-1:0] archMapData
);

    logic [physRegWidth-1:0] mapTable [archRegCount];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < archRegCount; i++) begin
                mapTable[i] <= physRegWidth'(i);   // Identity map
            end
        end else begin
            if (retireValid0) begin
                mapTable[retireLogical0] <= retirePhys0;
            end
            // Younger slot written last so it wins on a shared register
            if (retireValid1) begin
                mapTable[retireLogical1] <= retirePhys1;
            end
        end
    end

    assign archMapData = mapTable[archMapAddr];

    always_ff @(posedge clk) begin
        if (rst) begin
            freeValid0 <= 1'b0;
            freeValid1 <= 1'b0;
        end else begin
            freeValid0 <= retireValid0;
            freeValid1 <= retireValid1;
        end
    end

    always_ff @(posedge clk) begin
        freePhys0 <= retireStale0;
        freePhys1 <= retireStale1;
    end

endmodule

//--- commitStage.sv
`timescale 1ns/1ps

module commitStage import commitPkg::*; (
    input  logic                    clk,
    input  logic                    rst,

    input  logic                    headValid,
    input  uopEntry                 headUop0,
    input  uopEntry                 headUop1,
    output logic                    headRetire,

    output logic                    retireValid0,
    output logic                    retireValid1,
    output logic [archRegWidth-1:0] retireLogical0,
    output logic [archRegWidth-1:0] retireLogical1,
    output logic [physRegWidth-1:0] retirePhys0,
    output logic [physRegWidth-1:0] retirePhys1,
    output logic [physRegWidth-1:0] retireStale0,
    output logic [physRegWidth-1:0] retireStale1,

    output logic                    redirect,
    output logic [pcWidth-1:0]      redirectPc,
    output logic                    flushReq,

    output logic                    bpUpdateValid,
    output logic [pcWidth-1:0]      bpUpdatePc,
    output logic [pcWidth-1:0]      bpUpdateTarget,
    output logic                    bpUpdateTaken,
    output logic [1:0]              bpUpdateBim
);

    logic               slot0Branch;
    logic               dirMiss;
    logic               targetMiss;
    logic               mispredict;
    logic [pcWidth-1:0] actualTarget;
    logic               fire;       // Redirect pending for this cycle
    logic               waitSlot;   // Waiting for the delay-slot pair
    logic [pcWidth-1:0] heldPc;

    // Commit never stalls the head
    assign headRetire = headValid;

    assign slot0Branch = headUop0.valid && headUop0.kind != notBranch;
    assign dirMiss     = slot0Branch && headUop0.taken != headUop0.predTaken;

    // Target only matters when the branch actually went
    assign targetMiss = slot0Branch && headUop0.taken &&
                        headUop0.target != headUop0.predTarget;

    assign mispredict   = headValid && (dirMiss || targetMiss);
    assign actualTarget = headUop0.taken ? headUop0.target : headUop0.pc + 32'd8;

    always_ff @(posedge clk) begin
        if (rst) begin
            fire     <= 1'b0;
            waitSlot <= 1'b0;
        end else begin
            fire <= 1'b0;
            if (headValid) begin
                if (waitSlot) begin
                    fire     <= 1'b1;          // Delay slot has now retired
                    waitSlot <= 1'b0;
                end else if (mispredict) begin
                    fire     <= headUop1.valid;
                    waitSlot <= !headUop1.valid;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (headValid && !waitSlot && mispredict) begin
            heldPc <= actualTarget;
        end
    end

    assign redirect   = fire;
    assign flushReq   = fire;
    assign redirectPc = fire ? heldPc : '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            retireValid0  <= 1'b0;
            retireValid1  <= 1'b0;
            bpUpdateValid <= 1'b0;
        end else begin
            retireValid0  <= headValid && headUop0.valid && headUop0.dstWe;
            retireValid1  <= headValid && headUop1.valid && headUop1.dstWe;
            bpUpdateValid <= headValid && slot0Branch;
        end
    end

    // Rename and predictor payload
    always_ff @(posedge clk) begin
        retireLogical0 <= headUop0.dstLogical;
        retireLogical1 <= headUop1.dstLogical;
        retirePhys0    <= headUop0.dstPhys;
        retirePhys1    <= headUop1.dstPhys;
        retireStale0   <= headUop0.dstStale;
        retireStale1   <= headUop1.dstStale;

        bpUpdatePc     <= headUop0.pc;
        bpUpdateTarget <= headUop0.target;
        bpUpdateTaken  <= headUop0.taken;
        bpUpdateBim    <= headUop0.bimState;
    end

endmodule

//--- robQueue.sv
`timescale 1ns/1ps

module robQueue import commitPkg::*; #(
    parameter int  robDepth = 8,
    localparam int idxWidth = $clog2(robDepth)
) (
    input  logic                clk,
    input  logic                rst,

    input  logic                dispatchValid,
    input  uopEntry             dispatchUop0,
    input  uopEntry             dispatchUop1,

    input  logic                completeValid,
    input  logic [idxWidth-1:0] completeIndex,
    input  logic                completeSlot,
    input  logic                completeTaken,
    input  logic [pcWidth-1:0]  completeTarget,

    input  logic                headRetire,
    input  logic                flush,

    output logic                headValid,
    output uopEntry             headUop0,
    output uopEntry             headUop1,
    output logic                robFull,
    output logic                robEmpty
);

    uopEntry             slot0Mem [robDepth];
    uopEntry             slot1Mem [robDepth];
    logic [idxWidth-1:0] headPtr;
    logic [idxWidth-1:0] tailPtr;
    logic [idxWidth:0]   count;
    logic                accept;
    logic                retire;
    logic                slot0Ready;
    logic                slot1Ready;

    assign robFull  = count == (idxWidth + 1)'(robDepth);
    assign robEmpty = count == '0;

    // Strobes while full or during a flush are dropped
    assign accept = dispatchValid && !robFull && !flush;

    assign headUop0 = slot0Mem[headPtr];
    assign headUop1 = slot1Mem[headPtr];

    // Bubbles never complete, so only real slots are waited for
    assign slot0Ready = !headUop0.valid || headUop0.done;
    assign slot1Ready = !headUop1.valid || headUop1.done;

    // Head is hidden while the buffer is being flushed
    assign headValid = !robEmpty && slot0Ready && slot1Ready && !flush;
    assign retire    = headRetire && headValid;

    always_ff @(posedge clk) begin
        if (rst) begin
            headPtr <= '0;
            tailPtr <= '0;
            count   <= '0;
        end else if (flush) begin
            headPtr <= '0;
            tailPtr <= '0;
            count   <= '0;
        end else begin
            if (accept) begin
                tailPtr <= tailPtr + 1'b1;   // Wraps at robDepth
            end
            if (retire) begin
                headPtr <= headPtr + 1'b1;
            end
            count <= count + (idxWidth + 1)'(accept) - (idxWidth + 1)'(retire);
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            slot0Mem[tailPtr]      <= dispatchUop0;
            slot1Mem[tailPtr]      <= dispatchUop1;
            slot0Mem[tailPtr].done <= 1'b0;
            slot1Mem[tailPtr].done <= 1'b0;
        end

        // Completion may target any occupied entry in any order
        if (completeValid) begin
            if (completeSlot) begin
                slot1Mem[completeIndex].done   <= 1'b1;
                slot1Mem[completeIndex].taken  <= completeTaken;
                slot1Mem[completeIndex].target <= completeTarget;
            end else begin
                slot0Mem[completeIndex].done   <= 1'b1;
                slot0Mem[completeIndex].taken  <= completeTaken;
                slot0Mem[completeIndex].target <= completeTarget;
            end
        end
    end

endmodule

//--- commitPkg.sv
package commitPkg;

    // Register and address widths
    localparam int archRegWidth = 5;
    localparam int physRegWidth = 6;   // 64 physical registers
    localparam int pcWidth      = 32;

    // Number of logical registers held by the committed map
    localparam int archRegCount = 2 ** archRegWidth;

    typedef enum logic [1:0] {
        notBranch  = 2'd0,
        condBranch = 2'd1,
        jump       = 2'd2,
        jumpReg    = 2'd3
    } branchKind;

    // One micro-op as held in a reorder buffer slot
    typedef struct packed {
        logic                    valid;        // Low for a bubble
        logic [pcWidth-1:0]      pc;
        logic                    dstWe;
        logic [archRegWidth-1:0] dstLogical;
        logic [physRegWidth-1:0] dstPhys;
        logic [physRegWidth-1:0] dstStale;     // Previous mapping of dstLogical
        branchKind               kind;
        logic                    predTaken;
        logic [pcWidth-1:0]      predTarget;
        logic                    taken;        // Resolved direction
        logic [pcWidth-1:0]      target;       // Resolved target
        logic [1:0]              bimState;
        logic                    causeExc;
        logic                    done;
    } uopEntry;

endpackage
